/* include/cache_lookup_consts.svh */
/*
 * Geometry and buffering constants of the cache lookup path.
 * CACHE_WAYS must be a power of two, since the victim pointers wrap
 * by plain overflow. CACHE_SET_BITS must equal log2 of CACHE_SETS.
 * Changing a value here changes the widths of every packed record.
 */

`ifndef CACHE_LOOKUP_CONSTS_SVH
`define CACHE_LOOKUP_CONSTS_SVH

// ----------------------------------------
// Cache geometry
// ----------------------------------------

// Associativity of the cache
`define CACHE_WAYS 4

// Number of sets and width of the set index
`define CACHE_SETS 16
`define CACHE_SET_BITS 4

// Width of the tag kept in the directory
`define CACHE_TAG_BITS 8

// Number of lookup entries the FIFO can buffer
`define LOOKUP_FIFO_DEPTH 4

`endif

/* logic/cache_lookup_pkg.sv */
/*
 * Types shared by the lookup path. The widths come from the constants
 * header, so that header must be on the include path. The address has
 * no offset field, since no data array is modelled.
 */

`include "cache_lookup_consts.svh"

package cache_lookup_pkg;

    // ----------------------------------------
    // Scalar types
    // ----------------------------------------

    typedef logic [`CACHE_TAG_BITS-1:0] tag_t;
    typedef logic [`CACHE_SET_BITS-1:0] set_t;

    // One bit per way, used for valid bits and hit vectors
    typedef logic [`CACHE_WAYS-1:0] way_vec_t;

    // Binary way index, also the width of a victim pointer
    typedef logic [$clog2(`CACHE_WAYS)-1:0] way_idx_t;

    // ----------------------------------------
    // Records
    // ----------------------------------------

    // Request address, tag in the upper bits
    typedef struct packed {
        tag_t tag;
        set_t set;
    } address_t;

    // Snapshot of one set taken by a lookup, plus the requested address
    typedef struct packed {
        tag_t [`CACHE_WAYS-1:0] tags;
        way_vec_t               valid;
        address_t               addr;
    } lookup_entry_t;

    // Resolved lookup, way is zero on a miss
    typedef struct packed {
        logic     hit;
        way_vec_t way_hit;
        way_idx_t way;
        address_t addr;
    } lookup_result_t;

endpackage

/* logic/tag_directory.sv */
/*
 * Tag and valid directory with a round-robin victim pointer per set.
 * The lookup read takes two register stages: the set is captured at the
 * sampling edge and presented one edge later. A fill in the same cycle
 * as a lookup is not seen by that lookup. Tags have no reset, valid bits
 * and victim pointers do.
 */

`timescale 1ns/1ps

`include "cache_lookup_consts.svh"

module tag_directory (
    input  logic                           clk_i,
    input  logic                           arst_n_i,

    input  logic                           lookup_i,
    input  cache_lookup_pkg::address_t     lookup_addr_i,
    input  logic                           fill_i,
    input  cache_lookup_pkg::address_t     fill_addr_i,

    output logic                           entry_valid_o,
    output cache_lookup_pkg::lookup_entry_t entry_o
);

    // ----------------------------------------
    // Storage
    // ----------------------------------------

    cache_lookup_pkg::tag_t [`CACHE_WAYS-1:0] tag_mem [`CACHE_SETS];
    cache_lookup_pkg::way_vec_t               valid_q [`CACHE_SETS];
    cache_lookup_pkg::way_idx_t               victim_q [`CACHE_SETS];

    // Set and way touched by the current fill
    cache_lookup_pkg::set_t     fill_set;
    cache_lookup_pkg::way_idx_t fill_way;

    // First read stage
    logic                            rd_valid_q;
    cache_lookup_pkg::lookup_entry_t rd_entry_q;

    assign fill_set = fill_addr_i.set;
    assign fill_way = victim_q[fill_set];

    // ----------------------------------------
    // Fill path
    // ----------------------------------------

    // Valid bit and victim pointer of the filled set
    always_ff @(posedge clk_i or negedge arst_n_i) begin : fill_ctrl
        if (!arst_n_i) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                valid_q[s]  <= '0;
                victim_q[s] <= '0;
            end
        end else if (fill_i) begin
            valid_q[fill_set][fill_way] <= 1'b1;
            // Wraps back to way 0 after the last way
            victim_q[fill_set] <= fill_way + 1'b1;
        end
    end : fill_ctrl

    // The tag goes into the way the pointer names before it advances
    always_ff @(posedge clk_i) begin : tag_write
        if (fill_i) begin
            tag_mem[fill_set][fill_way] <= fill_addr_i.tag;
        end
    end : tag_write

    // ----------------------------------------
    // Lookup read
    // ----------------------------------------

    always_ff @(posedge clk_i or negedge arst_n_i) begin : read_strobe
        if (!arst_n_i) begin
            rd_valid_q    <= 1'b0;
            entry_valid_o <= 1'b0;
        end else begin
            rd_valid_q    <= lookup_i;
            entry_valid_o <= rd_valid_q;
        end
    end : read_strobe

    // Nonblocking reads return the state before a fill at the same edge
    always_ff @(posedge clk_i) begin : read_data
        if (lookup_i) begin
            rd_entry_q.tags  <= tag_mem[lookup_addr_i.set];
            rd_entry_q.valid <= valid_q[lookup_addr_i.set];
            rd_entry_q.addr  <= lookup_addr_i;
        end
        if (rd_valid_q) begin
            entry_o <= rd_entry_q;
        end
    end : read_data

endmodule : tag_directory

/* logic/lookup_fifo.sv */
/*
 * Circular FIFO with a type parameter for the payload.
 * A push while full is dropped and a pop while empty is ignored.
 * pop_data_o always shows the head, valid only while empty_o is low.
 * DEPTH must be at least 2.
 */

`timescale 1ns/1ps

module lookup_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk_i,
    input  logic     arst_n_i,

    input  logic     push_i,
    input  payload_t push_data_i,
    input  logic     pop_i,
    output payload_t pop_data_o,

    output logic     full_o,
    output logic     empty_o
);

    localparam int PTR_BITS = $clog2(DEPTH);
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];

    logic [PTR_BITS-1:0] wr_ptr_q;
    logic [PTR_BITS-1:0] rd_ptr_q;
    logic [CNT_BITS-1:0] count_q;

    // Qualified strobes
    logic do_push;
    logic do_pop;

    assign full_o  = (count_q == CNT_BITS'(DEPTH));
    assign empty_o = (count_q == '0);

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // ----------------------------------------
    // Pointers and occupancy
    // ----------------------------------------

    always_ff @(posedge clk_i or negedge arst_n_i) begin : ptr_ctrl
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                // Explicit wrap so DEPTH need not be a power of two
                wr_ptr_q <= (wr_ptr_q == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leaves the count unchanged
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end : ptr_ctrl

    // Storage
    always_ff @(posedge clk_i) begin : mem_write
        if (do_push) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end : mem_write

    // The head is read straight from the storage registers
    assign pop_data_o = mem[rd_ptr_q];

endmodule : lookup_fifo

/* logic/data_cache_hit_check.sv */
/*
 * Combinational tag compare across all ways of one set.
 * A way hits only if its valid bit is set. With unique tags per set the
 * hit vector is one-hot or zero, duplicates are not filtered here.
 */

`timescale 1ns/1ps

`include "cache_lookup_consts.svh"

module data_cache_hit_check (
    input  cache_lookup_pkg::tag_t [`CACHE_WAYS-1:0] cache_tag_i,
    input  cache_lookup_pkg::way_vec_t               cache_valid_i,
    input  cache_lookup_pkg::tag_t                   address_tag_i,

    output logic                                     hit_o,
    output cache_lookup_pkg::way_vec_t               way_hit_o
);

    cache_lookup_pkg::way_vec_t way_hit;

    // Compare every way in parallel
    always_comb begin : compare
        way_hit = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            way_hit[w] = (cache_tag_i[w] == address_tag_i) && cache_valid_i[w];
        end
    end : compare

    // Any way matching means a hit
    assign hit_o     = |way_hit;
    assign way_hit_o = way_hit;

endmodule : data_cache_hit_check

/* logic/lookup_resolver.sv */
/*
 * Drains the lookup FIFO and resolves each entry into a result.
 * A pop happens whenever the FIFO holds data and stall_i is low, so at
 * most one result leaves per cycle. The result register has no reset,
 * result_valid_o qualifies it.
 */

`timescale 1ns/1ps

`include "cache_lookup_consts.svh"

module lookup_resolver (
    input  logic                            clk_i,
    input  logic                            arst_n_i,

    input  logic                            stall_i,
    input  logic                            empty_i,
    input  cache_lookup_pkg::lookup_entry_t entry_i,
    output logic                            pop_o,

    output logic                            result_valid_o,
    output cache_lookup_pkg::lookup_result_t result_o
);

    logic                       hit;
    cache_lookup_pkg::way_vec_t way_hit;
    cache_lookup_pkg::way_idx_t way_idx;

    assign pop_o = !empty_i && !stall_i;

    data_cache_hit_check i_hit_check (
        .cache_tag_i   (entry_i.tags),
        .cache_valid_i (entry_i.valid),
        .address_tag_i (entry_i.addr.tag),
        .hit_o         (hit),
        .way_hit_o     (way_hit)
    );

    // One-hot to binary, stays zero on a miss
    always_comb begin : way_encode
        way_idx = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (way_hit[w]) begin
                way_idx = cache_lookup_pkg::way_idx_t'(w);
            end
        end
    end : way_encode

    // ----------------------------------------
    // Result register
    // ----------------------------------------

    always_ff @(posedge clk_i or negedge arst_n_i) begin : result_strobe
        if (!arst_n_i) begin
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= pop_o;
        end
    end : result_strobe

    always_ff @(posedge clk_i) begin : result_data
        if (pop_o) begin
            result_o.hit     <= hit;
            result_o.way_hit <= way_hit;
            result_o.way     <= way_idx;
            result_o.addr    <= entry_i.addr;
        end
    end : result_data

endmodule : lookup_resolver

/* logic/cache_lookup_top.sv */
/*
 * Tag lookup path of one cache port: directory, FIFO and resolver.
 * There is no ready towards the requester. A lookup entry that meets a
 * full FIFO is lost and overflow_o pulses in that cycle. stall_i is the
 * only back-pressure on the result side.
 */

`timescale 1ns/1ps

`include "cache_lookup_consts.svh"

module cache_lookup_top (
    input  logic                             clk_i,
    input  logic                             arst_n_i,

    input  logic                             lookup_i,
    input  cache_lookup_pkg::address_t       lookup_addr_i,
    input  logic                             fill_i,
    input  cache_lookup_pkg::address_t       fill_addr_i,
    input  logic                             stall_i,

    output logic                             result_valid_o,
    output cache_lookup_pkg::lookup_result_t result_o,
    output logic                             full_o,
    output logic                             overflow_o
);

    // Directory to FIFO
    logic                            entry_valid;
    cache_lookup_pkg::lookup_entry_t entry;

    // FIFO to resolver
    logic                            pop;
    logic                            empty;
    cache_lookup_pkg::lookup_entry_t head;

    tag_directory i_directory (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .lookup_i      (lookup_i),
        .lookup_addr_i (lookup_addr_i),
        .fill_i        (fill_i),
        .fill_addr_i   (fill_addr_i),
        .entry_valid_o (entry_valid),
        .entry_o       (entry)
    );

    lookup_fifo #(
        .payload_t (cache_lookup_pkg::lookup_entry_t),
        .DEPTH     (`LOOKUP_FIFO_DEPTH)
    ) i_fifo (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .push_i      (entry_valid),
        .push_data_i (entry),
        .pop_i       (pop),
        .pop_data_o  (head),
        .full_o      (full_o),
        .empty_o     (empty)
    );

    lookup_resolver i_resolver (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .stall_i        (stall_i),
        .empty_i        (empty),
        .entry_i        (head),
        .pop_o          (pop),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

    // A push into a full FIFO is dropped by the FIFO itself
    assign overflow_o = entry_valid && full_o;

endmodule : cache_lookup_top

/* testbench/cache_lookup_checker.sv */
/*
 * Protocol assertions for the cache lookup top level, attached by bind.
 * The way checks look at the registered result and hold only while
 * result_valid_o is high.
 */

`timescale 1ns/1ps

module cache_lookup_checker (
    input logic                             clk_i,
    input logic                             arst_n_i,
    input logic                             stall_i,
    input logic                             result_valid_i,
    input cache_lookup_pkg::lookup_result_t result_i,
    input logic                             full_i,
    input logic                             overflow_i
);

    // A resolved lookup names at most one way
    way_hit_onehot : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        result_valid_i |-> $onehot0(result_i.way_hit))
        else $error("way_hit is not one-hot or zero");

    hit_is_or_of_ways : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        result_valid_i |-> (result_i.hit == |result_i.way_hit))
        else $error("hit differs from the OR of way_hit");

    // Entries are only lost when the FIFO has no room
    overflow_needs_full : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        overflow_i |-> full_i)
        else $error("overflow pulsed while the FIFO was not full");

    // No pop under stall, so no result one cycle later
    no_result_after_stall : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $past(stall_i) |-> !result_valid_i)
        else $error("result left although stall was high the cycle before");

endmodule : cache_lookup_checker

bind cache_lookup_top cache_lookup_checker i_checker (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .stall_i        (stall_i),
    .result_valid_i (result_valid_o),
    .result_i       (result_o),
    .full_i         (full_o),
    .overflow_i     (overflow_o)
);

/* testbench/cache_lookup_tb.sv */
/*
 * Testbench for the cache lookup path. Inputs change on falling edges
 * and outputs are sampled there too. The model assumes tags are unique
 * within a set, so a fill of a tag already present is skipped.
 */

`timescale 1ns/1ps

`include "cache_lookup_consts.svh"

module cache_lookup_tb;

    typedef enum logic [3:0] {
        OP_IDLE, OP_LOOKUP, OP_FILL, OP_FILL_LOOKUP, OP_STALL_ON,
        OP_STALL_OFF, OP_DRAIN, OP_LOOKUP_DROP, OP_EXPECT_FULL
    } op_t;

    // One row of the stimulus table
    typedef struct packed {
        op_t                        op;
        cache_lookup_pkg::address_t addr;
    } stim_row_t;

    localparam int DRAIN_LIMIT = 60;
    localparam int FULL_LIMIT  = 20;

    logic                             clk_i;
    logic                             arst_n_i;
    logic                             lookup_i;
    cache_lookup_pkg::address_t       lookup_addr_i;
    logic                             fill_i;
    cache_lookup_pkg::address_t       fill_addr_i;
    logic                             stall_i;
    logic                             result_valid_o;
    cache_lookup_pkg::lookup_result_t result_o;
    logic                             full_o;
    logic                             overflow_o;

    // Reference model of the directory
    cache_lookup_pkg::tag_t m_tag [`CACHE_SETS][`CACHE_WAYS];
    logic                   m_valid [`CACHE_SETS][`CACHE_WAYS];
    int                     m_victim [`CACHE_SETS];

    stim_row_t                        stim_q[$];
    cache_lookup_pkg::lookup_result_t exp_q[$];
    int value_errors;
    int protocol_errors;
    int timeouts;
    int exp_overflows;
    int overflow_seen;

    cache_lookup_top i_dut (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .lookup_i       (lookup_i),
        .lookup_addr_i  (lookup_addr_i),
        .fill_i         (fill_i),
        .fill_addr_i    (fill_addr_i),
        .stall_i        (stall_i),
        .result_valid_o (result_valid_o),
        .result_o       (result_o),
        .full_o         (full_o),
        .overflow_o     (overflow_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------

    // A way hits when it is valid and holds the address tag
    function automatic cache_lookup_pkg::lookup_result_t predict(cache_lookup_pkg::address_t a);
        cache_lookup_pkg::lookup_result_t r;
        r = '0;
        r.addr = a;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (m_valid[a.set][w] && m_tag[a.set][w] == a.tag) begin
                r.hit        = 1'b1;
                r.way_hit[w] = 1'b1;
                r.way        = cache_lookup_pkg::way_idx_t'(w);
            end
        end
        return r;
    endfunction

    // Round-robin victim, one pointer per set
    function automatic void model_fill(cache_lookup_pkg::address_t a);
        int way;
        way = m_victim[a.set];
        m_tag[a.set][way]   = a.tag;
        m_valid[a.set][way] = 1'b1;
        m_victim[a.set]     = (way + 1) % `CACHE_WAYS;
    endfunction

    function automatic void add_row(op_t op, int set, int tag);
        stim_row_t row;
        row.op       = op;
        row.addr.set = cache_lookup_pkg::set_t'(set);
        row.addr.tag = cache_lookup_pkg::tag_t'(tag);
        stim_q.push_back(row);
    endfunction

    // ----------------------------------------
    // Drivers and waits
    // ----------------------------------------

    task automatic issue_lookup(cache_lookup_pkg::address_t a);
        lookup_i      = 1'b1;
        lookup_addr_i = a;
        exp_q.push_back(predict(a));
    endtask

    task automatic issue_fill(cache_lookup_pkg::address_t a, logic present);
        if (!present) begin
            fill_i      = 1'b1;
            fill_addr_i = a;
            model_fill(a);
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < DRAIN_LIMIT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            timeouts++;
            $display("Timeout at %0t: %0d lookups got no result", $time, exp_q.size());
        end else begin
            assert (!full_o) else begin
                value_errors++;
                $display("ERROR at %0t: full_o = %b, expected 0", $time, full_o);
            end
        end
    endtask

    task automatic wait_full();
        int cycles;
        cycles = 0;
        while (!full_o && cycles < FULL_LIMIT) begin
            @(negedge clk_i);
            cycles++;
        end
        assert (full_o) else begin
            timeouts++;
            $display("ERROR at %0t: full_o = %b, expected 1", $time, full_o);
        end
    endtask

    // Strobes last one cycle unless the next row raises them again
    task automatic apply_row(stim_row_t row);
        cache_lookup_pkg::lookup_result_t now;
        @(negedge clk_i);
        lookup_i = 1'b0;
        fill_i   = 1'b0;
        now      = predict(row.addr);
        case (row.op)
            OP_LOOKUP:      issue_lookup(row.addr);
            OP_FILL:        issue_fill(row.addr, now.hit);
            // The lookup sees the set before the fill
            OP_FILL_LOOKUP: begin
                issue_lookup(row.addr);
                issue_fill(row.addr, now.hit);
            end
            OP_LOOKUP_DROP: begin
                lookup_i      = 1'b1;
                lookup_addr_i = row.addr;
                exp_overflows++;
            end
            OP_STALL_ON:    stall_i = 1'b1;
            OP_STALL_OFF:   stall_i = 1'b0;
            OP_DRAIN:       wait_drain();
            OP_EXPECT_FULL: wait_full();
            default:        ;
        endcase
    endtask

    // ----------------------------------------
    // Result monitor
    // ----------------------------------------

    always @(negedge clk_i) begin : result_monitor
        cache_lookup_pkg::lookup_result_t exp;
        if (arst_n_i) begin
            if (overflow_o) begin
                overflow_seen++;
            end
            if (result_valid_o) begin
                assert (exp_q.size() != 0) else begin
                    protocol_errors++;
                    $display("A result arrived at %0t with no lookup waiting", $time);
                end
                if (exp_q.size() != 0) begin
                    exp = exp_q.pop_front();
                    assert (result_o == exp) else begin
                        value_errors++;
                        $display("ERROR at %0t: result_o = %h, expected %h",
                                 $time, result_o, exp);
                    end
                end
            end
        end
    end : result_monitor

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    initial begin : stimulus
        arst_n_i = 1'b0;
        lookup_i = 1'b0;
        fill_i = 1'b0;
        stall_i = 1'b0;
        lookup_addr_i = '0;
        fill_addr_i = '0;
        value_errors = 0;
        protocol_errors = 0;
        timeouts = 0;
        exp_overflows = 0;
        overflow_seen = 0;
        void'($urandom(32'h8c70_874d));
        for (int s = 0; s < `CACHE_SETS; s++) begin
            m_victim[s] = 0;
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_tag[s][w] = '0;
            end
        end

        // Empty directory misses everywhere
        add_row(OP_LOOKUP, 3, 'h11);
        add_row(OP_LOOKUP, 0, 'h00);
        add_row(OP_LOOKUP, 15, 'hff);
        add_row(OP_DRAIN, 0, 0);
        // Fills land in ways 0 and 1, other sets are unaffected
        add_row(OP_FILL, 2, 'h21);
        add_row(OP_LOOKUP, 2, 'h21);
        add_row(OP_LOOKUP, 5, 'h21);
        add_row(OP_FILL, 2, 'h22);
        add_row(OP_LOOKUP, 2, 'h22);
        // Fifth fill into set 7 evicts the first tag
        for (int t = 'h71; t <= 'h75; t++) begin
            add_row(OP_FILL, 7, t);
        end
        for (int t = 'h71; t <= 'h75; t++) begin
            add_row(OP_LOOKUP, 7, t);
        end
        // Same-cycle fill misses, the next cycle hits
        add_row(OP_FILL_LOOKUP, 9, 'h90);
        add_row(OP_LOOKUP, 9, 'h90);
        // Stalled result side fills the FIFO and drops one entry
        add_row(OP_DRAIN, 0, 0);
        add_row(OP_STALL_ON, 0, 0);
        for (int i = 0; i < `LOOKUP_FIFO_DEPTH; i++) begin
            add_row(OP_LOOKUP, 7, 'h72 + i);
        end
        add_row(OP_LOOKUP_DROP, 2, 'h21);
        add_row(OP_EXPECT_FULL, 0, 0);
        add_row(OP_STALL_OFF, 0, 0);
        add_row(OP_DRAIN, 0, 0);
        // Random mix over a few sets with more tags than ways
        for (int i = 0; i < 80; i++) begin
            add_row(op_t'(OP_LOOKUP + ($urandom % 3)), 8 + ($urandom % 4),
                    'ha0 + ($urandom % 6));
        end

        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;

        foreach (stim_q[i]) begin
            apply_row(stim_q[i]);
        end
        apply_row('{op: OP_IDLE, addr: '0});
        wait_drain();

        assert (overflow_seen == exp_overflows) else begin
            value_errors++;
            $display("ERROR at %0t: overflow_o pulses = %0d, expected %0d",
                     $time, overflow_seen, exp_overflows);
        end

        $display("Summary: %0d value errors, %0d protocol errors, %0d timeouts",
                 value_errors, protocol_errors, timeouts);
        if (value_errors == 0 && protocol_errors == 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end : stimulus

endmodule : cache_lookup_tb

/* compile.f */
+incdir+include
logic/cache_lookup_pkg.sv
logic/tag_directory.sv
logic/lookup_fifo.sv
logic/data_cache_hit_check.sv
logic/lookup_resolver.sv
logic/cache_lookup_top.sv
testbench/cache_lookup_checker.sv
testbench/cache_lookup_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the cache lookup testbench with Verilator and runs it.
# The exit status is nonzero unless the testbench reports a pass.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f compile.f \
        --top-module cache_lookup_tb -o sim_cache_lookup; then
    echo "Verilator build failed"
    exit 1
fi

if ! sim_out=$(./obj_dir/sim_cache_lookup); then
    echo "$sim_out"
    echo "Simulation exited with an error status"
    exit 1
fi

echo "$sim_out"

if echo "$sim_out" | grep -qx "All checks passed"; then
    exit 0
else
    echo "Simulation did not report a pass"
    exit 1
fi
